// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;
  localparam int NUM_REGS = 32;

  // stages times bits per stage covers the whole word
  localparam int DIV_STAGES = 8;
  localparam int DIV_BITS_PER_STAGE = 4;

  // width of the count of divides from issue to retire
  localparam int DIV_CNT_W = $clog2(DIV_STAGES + 4);

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;

  // major opcodes
  localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
  localparam opcode_t OPCODE_OP = 7'b0110011;
  localparam opcode_t OPCODE_LUI = 7'b0110111;

  // funct7 encodings
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // LUI passes operand b straight through
    ALU_PASS
  } alu_op_e;

  // matches funct3[1:0] of the M-extension divides
  typedef enum logic [1:0] {
    DOP_DIV  = 2'b00,
    DOP_DIVU = 2'b01,
    DOP_REM  = 2'b10,
    DOP_REMU = 2'b11
  } div_op_e;

endpackage

`default_nettype wire

// ==== divider/div_unsigned_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unsigned_pipe (
  input  logic          clk,
  input  logic          rst,
  input  logic          hold,
  input  rv_pkg::xlen_t dividend,
  input  rv_pkg::xlen_t divisor,
  output rv_pkg::xlen_t quotient,
  output rv_pkg::xlen_t remainder
);
  import rv_pkg::*;

  // restoring iterations for one stage
  // the dividend shifts out of dq while quotient bits shift in
  function automatic logic [63:0] div_step(xlen_t rem_in, xlen_t dq_in, xlen_t dvs);
    logic [32:0] shifted;
    xlen_t       rem;
    xlen_t       dq;
    rem = rem_in;
    dq  = dq_in;
    for (int i = 0; i < DIV_BITS_PER_STAGE; i++) begin
      shifted = {rem, dq[31]};
      if (shifted >= {1'b0, dvs}) begin
        rem = xlen_t'(shifted - {1'b0, dvs});
        dq  = {dq[30:0], 1'b1};
      end else begin
        rem = shifted[31:0];
        dq  = {dq[30:0], 1'b0};
      end
    end
    return {rem, dq};
  endfunction

  for (genvar s = 0; s < DIV_STAGES; s++) begin : g_stage
    xlen_t rem_in, dq_in, dvs_in;
    xlen_t rem_r, dq_r, dvs_r;

    if (s == 0) begin : g_head
      assign rem_in = '0;
      assign dq_in  = dividend;
      assign dvs_in = divisor;
    end else begin : g_body
      assign rem_in = g_stage[s-1].rem_r;
      assign dq_in  = g_stage[s-1].dq_r;
      assign dvs_in = g_stage[s-1].dvs_r;
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        rem_r <= '0;
        dq_r  <= '0;
        dvs_r <= '0;
      end else if (!hold) begin
        {rem_r, dq_r} <= div_step(rem_in, dq_in, dvs_in);
        dvs_r         <= dvs_in;
      end
    end
  end

  // a zero divisor leaves all ones and the dividend
  assign quotient  = g_stage[DIV_STAGES-1].dq_r;
  assign remainder = g_stage[DIV_STAGES-1].rem_r;

endmodule

`default_nettype wire

// ==== divider/div_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic             hold,
  input  logic             div_valid,
  input  rv_pkg::div_op_e  div_op,
  input  rv_pkg::xlen_t    div_a,
  input  rv_pkg::xlen_t    div_b,
  input  rv_pkg::reg_idx_t div_rd,
  output logic             div_res_valid,
  output rv_pkg::reg_idx_t div_res_rd,
  output rv_pkg::xlen_t    div_res_data
);
  import rv_pkg::*;

  logic a_neg, b_neg;

  // conditioning register
  logic     c_valid, c_neg_q, c_neg_r, c_zero;
  div_op_e  c_op;
  reg_idx_t c_rd;
  xlen_t    c_a_mag, c_b_mag;

  // side info that runs alongside the stages
  logic [DIV_STAGES-1:0] s_valid, s_neg_q, s_neg_r, s_zero;
  div_op_e               s_op [DIV_STAGES];
  reg_idx_t              s_rd [DIV_STAGES];

  xlen_t quotient, remainder;

  assign a_neg = (div_op == DOP_DIV || div_op == DOP_REM) && div_a[31];
  assign b_neg = (div_op == DOP_DIV || div_op == DOP_REM) && div_b[31];

  always_ff @(posedge clk) begin
    if (rst) begin
      c_valid <= 1'b0;
      s_valid <= '0;
    end else if (!hold) begin
      c_valid <= div_valid;
      s_valid <= {s_valid[DIV_STAGES-2:0], c_valid};
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      c_op    <= div_op;
      c_rd    <= div_rd;
      c_zero  <= (div_b == '0);
      c_neg_q <= a_neg ^ b_neg;
      c_neg_r <= a_neg;
      c_a_mag <= a_neg ? -div_a : div_a;
      c_b_mag <= b_neg ? -div_b : div_b;
      s_neg_q <= {s_neg_q[DIV_STAGES-2:0], c_neg_q};
      s_neg_r <= {s_neg_r[DIV_STAGES-2:0], c_neg_r};
      s_zero  <= {s_zero[DIV_STAGES-2:0], c_zero};
      s_op[0] <= c_op;
      s_rd[0] <= c_rd;
      for (int s = 1; s < DIV_STAGES; s++) begin
        s_op[s] <= s_op[s-1];
        s_rd[s] <= s_rd[s-1];
      end
    end
  end

  div_unsigned_pipe u_pipe (
    .clk       (clk),
    .rst       (rst),
    .hold      (hold),
    .dividend  (c_a_mag),
    .divisor   (c_b_mag),
    .quotient  (quotient),
    .remainder (remainder)
  );

  // min int by -1 needs no special case, the magnitude 2^31 negates to itself
  // and the remainder is zero
  always_comb begin
    if (s_op[DIV_STAGES-1] == DOP_REM || s_op[DIV_STAGES-1] == DOP_REMU) begin
      div_res_data = s_neg_r[DIV_STAGES-1] ? -remainder : remainder;
    end else if (s_zero[DIV_STAGES-1]) begin
      div_res_data = '1;
    end else begin
      div_res_data = s_neg_q[DIV_STAGES-1] ? -quotient : quotient;
    end
  end

  assign div_res_valid = s_valid[DIV_STAGES-1];
  assign div_res_rd    = s_rd[DIV_STAGES-1];

  // a stalled divide keeps its op until the pipeline moves
  assert property (@(posedge clk) disable iff (rst) div_valid && hold |=> $stable(div_op))
    else $error("div_unit: div_op changed while held");

endmodule

`default_nettype wire

// ==== hdl/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic             hold,
  input  logic             alu_valid,
  input  rv_pkg::alu_op_e  alu_op,
  input  rv_pkg::xlen_t    alu_a,
  input  rv_pkg::xlen_t    alu_b,
  input  rv_pkg::reg_idx_t alu_rd,
  input  logic             alu_illegal,
  output logic             alu_res_valid,
  output rv_pkg::reg_idx_t alu_res_rd,
  output rv_pkg::xlen_t    alu_res_data,
  output logic             alu_res_illegal
);
  import rv_pkg::*;

  logic [4:0] shamt;
  xlen_t      result;

  assign shamt = alu_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  result = alu_a + alu_b;
      ALU_SUB:  result = alu_a - alu_b;
      ALU_SLL:  result = alu_a << shamt;
      ALU_SLT:  result = {31'b0, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU: result = {31'b0, alu_a < alu_b};
      ALU_XOR:  result = alu_a ^ alu_b;
      ALU_SRL:  result = alu_a >> shamt;
      ALU_SRA:  result = $signed(alu_a) >>> shamt;
      ALU_OR:   result = alu_a | alu_b;
      ALU_AND:  result = alu_a & alu_b;
      ALU_PASS: result = alu_b;
      default:  result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_res_valid <= 1'b0;
    end else if (!hold) begin
      alu_res_valid <= alu_valid;
    end
  end

  // illegal words carry a zero result
  always_ff @(posedge clk) begin
    if (!hold) begin
      alu_res_rd      <= alu_rd;
      alu_res_illegal <= alu_illegal;
      alu_res_data    <= alu_illegal ? '0 : result;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/issue_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_decode (
  input  logic             clk,
  input  logic             rst,
  input  logic             insn_valid,
  output logic             insn_ready,
  input  rv_pkg::insn_t    insn,
  input  logic             hold,
  input  logic             wb_en,
  input  rv_pkg::reg_idx_t wb_rd,
  input  rv_pkg::xlen_t    wb_data,
  input  logic             div_retired,
  output logic             alu_valid,
  output rv_pkg::alu_op_e  alu_op,
  output rv_pkg::xlen_t    alu_a,
  output rv_pkg::xlen_t    alu_b,
  output rv_pkg::reg_idx_t alu_rd,
  output logic             alu_illegal,
  output logic             div_valid,
  output rv_pkg::div_op_e  div_op,
  output rv_pkg::xlen_t    div_a,
  output rv_pkg::xlen_t    div_b,
  output rv_pkg::reg_idx_t div_rd
);
  import rv_pkg::*;

  opcode_t    opcode;
  reg_idx_t   rd, rs1, rs2;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i, imm_u, shamt_ext;

  xlen_t regs [NUM_REGS];
  xlen_t rs1_data, rs2_data;

  logic    is_alu, is_div, legal, use_rs1, use_rs2, alt_op;
  alu_op_e dec_op;
  xlen_t   dec_b;

  logic [NUM_REGS-1:0]  busy;
  logic [DIV_CNT_W-1:0] div_busy_count;
  reg_idx_t             issue_rd;
  logic                 ready_en, src_busy, dst_busy, order_stall, fire;

  assign {funct7, rs2, rs1, funct3, rd, opcode} = insn;
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign shamt_ext = {27'b0, insn[24:20]};
  assign imm_u = {insn[31:12], 12'b0};

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // classify the word and pick operand b
  always_comb begin
    is_alu  = 1'b0;
    is_div  = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    alt_op  = 1'b0;
    dec_b   = imm_i;
    case (opcode)
      OPCODE_OP_IMM: begin
        use_rs1 = 1'b1;
        alt_op  = (funct3 == 3'b101) && (funct7 == FUNCT7_ALT);
        if (funct3[1:0] == 2'b01) begin
          // shift immediates reuse the top bits as funct7
          dec_b  = shamt_ext;
          is_alu = (funct7 == FUNCT7_BASE) || alt_op;
        end else begin
          is_alu = 1'b1;
        end
      end
      OPCODE_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        dec_b   = rs2_data;
        alt_op  = (funct7 == FUNCT7_ALT);
        is_alu  = (funct7 == FUNCT7_BASE) ||
                  (alt_op && (funct3 == 3'b000 || funct3 == 3'b101));
        // multiplies in the lower funct3 half are not taken
        is_div  = (funct7 == FUNCT7_MULDIV) && funct3[2];
      end
      OPCODE_LUI: begin
        is_alu = 1'b1;
        dec_b  = imm_u;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  dec_op = alt_op ? ALU_SUB : ALU_ADD;
      3'b001:  dec_op = ALU_SLL;
      3'b010:  dec_op = ALU_SLT;
      3'b011:  dec_op = ALU_SLTU;
      3'b100:  dec_op = ALU_XOR;
      3'b101:  dec_op = alt_op ? ALU_SRA : ALU_SRL;
      3'b110:  dec_op = ALU_OR;
      default: dec_op = ALU_AND;
    endcase
    if (opcode == OPCODE_LUI) begin
      dec_op = ALU_PASS;
    end
  end

  // illegal words travel the ALU path with rd 0
  assign legal    = is_alu || is_div;
  assign issue_rd = legal ? rd : '0;

  assign src_busy = (use_rs1 && busy[rs1]) || (use_rs2 && busy[rs2]);
  assign dst_busy = busy[issue_rd];
  // the ALU path is shorter, so it waits until the divider drains
  assign order_stall = !is_div && (div_busy_count != '0);

  assign insn_ready = ready_en && !hold && !src_busy && !dst_busy && !order_stall;
  assign fire = insn_valid && insn_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_en       <= 1'b0;
      busy           <= '0;
      div_busy_count <= '0;
    end else begin
      ready_en <= 1'b1;
      if (wb_en) begin
        busy[wb_rd] <= 1'b0;
      end
      if (fire && issue_rd != '0) begin
        busy[issue_rd] <= 1'b1;
      end
      div_busy_count <= div_busy_count + DIV_CNT_W'(fire && is_div)
                        - DIV_CNT_W'(div_retired);
    end
  end

  // register file with x0 masked on read
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // issue register
  always_ff @(posedge clk) begin
    if (rst) begin
      alu_valid <= 1'b0;
      div_valid <= 1'b0;
    end else if (!hold) begin
      alu_valid <= fire && !is_div;
      div_valid <= fire && is_div;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      alu_op      <= dec_op;
      alu_a       <= rs1_data;
      alu_b       <= dec_b;
      alu_rd      <= issue_rd;
      alu_illegal <= !legal;
      div_op      <= div_op_e'(funct3[1:0]);
      div_a       <= rs1_data;
      div_b       <= rs2_data;
      div_rd      <= issue_rd;
    end
  end

  // a source is never written back on the same edge that issues its reader
  assert property (@(posedge clk) disable iff (rst)
    fire && wb_en |-> !((use_rs1 && wb_rd == rs1) || (use_rs2 && wb_rd == rs2)))
    else $error("issue_decode: word issued while a source register was busy");

endmodule

`default_nettype wire

// ==== hdl/retire_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_merge (
  input  logic             clk,
  input  logic             rst,
  input  logic             alu_res_valid,
  input  rv_pkg::reg_idx_t alu_res_rd,
  input  rv_pkg::xlen_t    alu_res_data,
  input  logic             alu_res_illegal,
  input  logic             div_res_valid,
  input  rv_pkg::reg_idx_t div_res_rd,
  input  rv_pkg::xlen_t    div_res_data,
  input  logic             retire_ready,
  output logic             retire_valid,
  output rv_pkg::reg_idx_t retire_rd,
  output rv_pkg::xlen_t    retire_data,
  output logic             retire_illegal,
  output logic             hold,
  output logic             wb_en,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::xlen_t    wb_data,
  output logic             div_retired
);
  import rv_pkg::*;

  logic xfer;
  logic ret_from_div;

  // a stalled retire freezes every stage behind it
  assign hold = retire_valid && !retire_ready;
  assign xfer = retire_valid && retire_ready;

  assign wb_en       = xfer && (retire_rd != '0);
  assign wb_rd       = retire_rd;
  assign wb_data     = retire_data;
  assign div_retired = xfer && ret_from_div;

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
    end else if (!hold) begin
      retire_valid <= alu_res_valid || div_res_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      ret_from_div   <= div_res_valid;
      retire_rd      <= div_res_valid ? div_res_rd : alu_res_rd;
      retire_data    <= div_res_valid ? div_res_data : alu_res_data;
      retire_illegal <= !div_res_valid && alu_res_illegal;
    end
  end

  // issue ordering keeps the two result paths apart
  assert property (@(posedge clk) disable iff (rst) !(alu_res_valid && div_res_valid))
    else $error("retire_merge: ALU and divider results valid together");

endmodule

`default_nettype wire

// ==== hdl/int_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_exec_core (
  input  logic             clk,
  input  logic             rst,
  input  logic             insn_valid,
  output logic             insn_ready,
  input  rv_pkg::insn_t    insn,
  output logic             retire_valid,
  input  logic             retire_ready,
  output rv_pkg::reg_idx_t retire_rd,
  output rv_pkg::xlen_t    retire_data,
  output logic             retire_illegal
);
  import rv_pkg::*;

  logic     hold;
  logic     wb_en;
  reg_idx_t wb_rd;
  xlen_t    wb_data;
  logic     div_retired;

  // issue to ALU
  logic     alu_valid;
  alu_op_e  alu_op;
  xlen_t    alu_a;
  xlen_t    alu_b;
  reg_idx_t alu_rd;
  logic     alu_illegal;

  // issue to divider
  logic     div_valid;
  div_op_e  div_op;
  xlen_t    div_a;
  xlen_t    div_b;
  reg_idx_t div_rd;

  // unit results
  logic     alu_res_valid;
  reg_idx_t alu_res_rd;
  xlen_t    alu_res_data;
  logic     alu_res_illegal;
  logic     div_res_valid;
  reg_idx_t div_res_rd;
  xlen_t    div_res_data;

  issue_decode u_issue (
    .clk         (clk),
    .rst         (rst),
    .insn_valid  (insn_valid),
    .insn_ready  (insn_ready),
    .insn        (insn),
    .hold        (hold),
    .wb_en       (wb_en),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .div_retired (div_retired),
    .alu_valid   (alu_valid),
    .alu_op      (alu_op),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .alu_rd      (alu_rd),
    .alu_illegal (alu_illegal),
    .div_valid   (div_valid),
    .div_op      (div_op),
    .div_a       (div_a),
    .div_b       (div_b),
    .div_rd      (div_rd)
  );

  alu_unit u_alu (
    .clk             (clk),
    .rst             (rst),
    .hold            (hold),
    .alu_valid       (alu_valid),
    .alu_op          (alu_op),
    .alu_a           (alu_a),
    .alu_b           (alu_b),
    .alu_rd          (alu_rd),
    .alu_illegal     (alu_illegal),
    .alu_res_valid   (alu_res_valid),
    .alu_res_rd      (alu_res_rd),
    .alu_res_data    (alu_res_data),
    .alu_res_illegal (alu_res_illegal)
  );

  div_unit u_div (
    .clk           (clk),
    .rst           (rst),
    .hold          (hold),
    .div_valid     (div_valid),
    .div_op        (div_op),
    .div_a         (div_a),
    .div_b         (div_b),
    .div_rd        (div_rd),
    .div_res_valid (div_res_valid),
    .div_res_rd    (div_res_rd),
    .div_res_data  (div_res_data)
  );

  retire_merge u_retire (
    .clk             (clk),
    .rst             (rst),
    .alu_res_valid   (alu_res_valid),
    .alu_res_rd      (alu_res_rd),
    .alu_res_data    (alu_res_data),
    .alu_res_illegal (alu_res_illegal),
    .div_res_valid   (div_res_valid),
    .div_res_rd      (div_res_rd),
    .div_res_data    (div_res_data),
    .retire_ready    (retire_ready),
    .retire_valid    (retire_valid),
    .retire_rd       (retire_rd),
    .retire_data     (retire_data),
    .retire_illegal  (retire_illegal),
    .hold            (hold),
    .wb_en           (wb_en),
    .wb_rd           (wb_rd),
    .wb_data         (wb_data),
    .div_retired     (div_retired)
  );

endmodule

`default_nettype wire

// ==== verification/exec_model.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
  if (got !== want) begin
    $display("mismatch %s: got %h, expected %h", name, got, want);
    stop_on_failure();
  end
endtask

// integer results by funct3 with alt selecting sub and sra
function automatic xlen_t alu_model(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
  logic [4:0] sh;
  xlen_t      fill;
  sh = b[4:0];
  // sign bits shifted in from the left for sra
  fill = a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0;
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << sh;
    3'b010:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
    3'b011:  return {31'd0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return alt ? ((a >> sh) | fill) : (a >> sh);
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

// sel is funct3[1:0] where bit 1 picks the remainder and bit 0 unsigned
function automatic xlen_t div_model(logic [1:0] sel, xlen_t a, xlen_t b);
  int sa;
  int sb;
  sa = a;
  sb = b;
  if (b == 32'd0) begin
    return sel[1] ? a : 32'hFFFF_FFFF;
  end
  if (!sel[0] && a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
    return sel[1] ? 32'd0 : a;
  end
  case (sel)
    2'b00:   return xlen_t'(sa / sb);
    2'b01:   return a / b;
    2'b10:   return xlen_t'(sa % sb);
    default: return a % b;
  endcase
endfunction

// packed as {illegal, rd, data}
function automatic logic [37:0] model_result(insn_t w, xlen_t a, xlen_t b);
  logic [6:0] op;
  logic [6:0] f7;
  logic [2:0] f3;
  xlen_t      imm;
  xlen_t      res;
  logic       ok;
  op  = w[6:0];
  f3  = w[14:12];
  f7  = w[31:25];
  imm = {{20{w[31]}}, w[31:20]};
  ok  = 1'b0;
  res = '0;
  case (op)
    OPCODE_LUI: begin
      ok  = 1'b1;
      res = {w[31:12], 12'h000};
    end
    OPCODE_OP_IMM: begin
      if (f3 == 3'b001) begin
        ok = (f7 == FUNCT7_BASE);
      end else if (f3 == 3'b101) begin
        ok = (f7 == FUNCT7_BASE) || (f7 == FUNCT7_ALT);
      end else begin
        ok = 1'b1;
      end
      res = alu_model(f3, (f3 == 3'b101) && (f7 == FUNCT7_ALT), a, imm);
    end
    OPCODE_OP: begin
      if (f7 == FUNCT7_MULDIV) begin
        // multiplies sit in the lower funct3 half and are not taken
        ok  = f3[2];
        res = div_model(f3[1:0], a, b);
      end else begin
        ok  = (f7 == FUNCT7_BASE) ||
              ((f7 == FUNCT7_ALT) && (f3 == 3'b000 || f3 == 3'b101));
        res = alu_model(f3, f7 == FUNCT7_ALT, a, b);
      end
    end
    default: ok = 1'b0;
  endcase
  if (!ok) begin
    return {1'b1, 5'd0, 32'd0};
  end
  return {1'b0, w[11:7], res};
endfunction

`endif

// ==== verification/tb_int_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_int_exec_core;
  import rv_pkg::*;

  localparam int NUM_WORDS  = 2000;
  localparam int WAIT_LIMIT = 1000;

  logic     clk;
  logic     rst;
  logic     insn_valid;
  logic     insn_ready;
  insn_t    insn;
  logic     retire_valid;
  logic     retire_ready;
  reg_idx_t retire_rd;
  xlen_t    retire_data;
  logic     retire_illegal;

  logic [31:0] lfsr_state = 32'h4701_a6f8;
  logic [37:0] expect_q[$];
  xlen_t       model_regs [NUM_REGS];
  logic        took;
  int          accepted;
  int          retired;

  int_exec_core u_dut (
    .clk            (clk),
    .rst            (rst),
    .insn_valid     (insn_valid),
    .insn_ready     (insn_ready),
    .insn           (insn),
    .retire_valid   (retire_valid),
    .retire_ready   (retire_ready),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .retire_illegal (retire_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  `include "exec_model.svh"

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic insn_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  function automatic insn_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd);
    return {imm, rs1, f3, rd, OPCODE_OP_IMM};
  endfunction

  // registers come from x0..x7 so that words often depend on each other
  function automatic insn_t random_word();
    logic [31:0] cls;
    logic [31:0] sel;
    logic [31:0] imm;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    insn_t       w;
    cls = random_bits(3);
    sel = random_bits(2);
    imm = random_bits(20);
    rd  = 5'(random_bits(3));
    rs1 = 5'(random_bits(3));
    rs2 = 5'(random_bits(3));
    f3  = 3'(random_bits(3));
    case (sel)
      32'd1:   f7 = FUNCT7_ALT;
      32'd2:   f7 = FUNCT7_MULDIV;
      default: f7 = FUNCT7_BASE;
    endcase
    case (cls)
      32'd0, 32'd1: begin
        w = enc_i(imm[11:0], rs1, f3, rd);
        // shift immediates now and then get a junk funct7
        if (f3[1:0] == 2'b01) begin
          w[31:25] = (sel == 32'd2) ? imm[18:12] : f7;
        end
      end
      32'd2, 32'd3: w = enc_r(f7, rs2, rs1, f3, rd);
      32'd4:        w = {imm[19:0], rd, OPCODE_LUI};
      32'd5, 32'd6: w = enc_r(FUNCT7_MULDIV, rs2, rs1, {1'b1, f3[1:0]}, rd);
      default:      w = random_bits(32);
    endcase
    return w;
  endfunction

  function automatic void accept_word(input insn_t w);
    logic [37:0] res;
    res = model_result(w, model_regs[w[19:15]], model_regs[w[24:20]]);
    if (!res[37] && res[36:32] != 5'd0) begin
      model_regs[res[36:32]] = res[31:0];
    end
    expect_q.push_back(res);
    accepted++;
  endfunction

  task automatic check_retire();
    logic [37:0] want;
    if (expect_q.size() == 0) begin
      $display("retire transfer seen with no accepted word outstanding");
      stop_on_failure();
    end else begin
      want = expect_q.pop_front();
      retired++;
      check_value("retire_illegal", 32'(retire_illegal), 32'(want[37]));
      check_value("retire_rd", 32'(retire_rd), 32'(want[36:32]));
      if (!want[37]) begin
        check_value("retire_data", retire_data, want[31:0]);
      end
    end
  endtask

  // drive at the falling edge, sample both handshakes before the rising edge
  task automatic run_cycle(input logic valid, input insn_t word);
    @(negedge clk);
    insn_valid   = valid;
    insn         = word;
    retire_ready = (random_bits(2) != 0);
    #1;
    took = valid && insn_ready;
    if (took) begin
      accept_word(word);
    end
    if (retire_valid && retire_ready) begin
      check_retire();
    end
  endtask

  task automatic issue_word(input insn_t w);
    int waited;
    waited = 0;
    if (random_bits(2) == 0) begin
      run_cycle(1'b0, '0);
    end
    run_cycle(1'b1, w);
    while (!took) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: instruction word %h was never accepted", w);
        stop_on_failure();
      end else begin
        run_cycle(1'b1, w);
      end
    end
  endtask

  initial begin
    int    waited;
    insn_t directed[$];
    rst          = 1'b1;
    insn_valid   = 1'b0;
    insn         = '0;
    retire_ready = 1'b0;
    took         = 1'b0;
    accepted     = 0;
    retired      = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end

    repeat (8) begin
      @(negedge clk);
      check_value("retire_valid", 32'(retire_valid), 32'd0);
    end
    rst = 1'b0;
    run_cycle(1'b0, '0);
    check_value("retire_valid", 32'(retire_valid), 32'd0);
    waited = 0;
    while (!insn_ready) begin
      if (waited > WAIT_LIMIT) begin
        $display("timeout: insn_ready never rose after reset");
        stop_on_failure();
      end else begin
        run_cycle(1'b0, '0);
        waited++;
      end
    end

    // x1 = min int, x2 = -1, x3 = -7
    directed.push_back({20'h80000, 5'd1, OPCODE_LUI});
    directed.push_back(enc_i(12'hfff, 5'd0, 3'b000, 5'd2));
    directed.push_back(enc_i(12'hff9, 5'd0, 3'b000, 5'd3));
    for (int f = 4; f < 8; f++) begin
      directed.push_back(enc_r(FUNCT7_MULDIV, 5'd2, 5'd1, 3'(f), 5'd4));
      directed.push_back(enc_r(FUNCT7_MULDIV, 5'd0, 5'd3, 3'(f), 5'd5));
      // reads the divide just before it
      directed.push_back(enc_r(FUNCT7_MULDIV, 5'd4, 5'd3, 3'(f), 5'd4));
    end
    directed.push_back(enc_i(12'h005, 5'd3, 3'b000, 5'd0));
    directed.push_back(enc_r(FUNCT7_BASE, 5'd0, 5'd0, 3'b000, 5'd6));
    foreach (directed[i]) begin
      issue_word(directed[i]);
    end

    for (int i = 0; i < NUM_WORDS; i++) begin
      issue_word(random_word());
    end

    waited = 0;
    while (retired != accepted) begin
      if (waited > WAIT_LIMIT) begin
        $display("timeout: %0d accepted words never retired", accepted - retired);
        stop_on_failure();
      end else begin
        run_cycle(1'b0, '0);
        waited++;
      end
    end
    // a late extra retire would find the queue empty
    repeat (20) run_cycle(1'b0, '0);

    if (expect_q.size() == 0 && retired == accepted) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("accepted %0d words but retired %0d", accepted, retired);
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verification
common/rv_pkg.sv
divider/div_unsigned_pipe.sv
divider/div_unit.sv
hdl/alu_unit.sv
hdl/issue_decode.sv
hdl/retire_merge.sv
hdl/int_exec_core.sv
verification/tb_int_exec_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

TOP=tb_int_exec_core
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ "$sim_status" -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
echo "simulation finished without errors"
exit 0
